// File: verilog/isa_pkg.sv
package isa_pkg;

  // register-register view.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate view, also carries the upper bits of lui.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add   = 3'b000;
  localparam logic [2:0] f3_priv  = 3'b000;
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  localparam logic [11:0] imm_ecall = 12'h000;
  localparam logic [11:0] imm_mret  = 12'h302;

  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_marchid   = 12'hf12;

  // mstatus field positions.
  localparam int mstatus_mie    = 3;
  localparam int mstatus_mpie   = 7;
  localparam int mstatus_mpp_lo = 11;

  localparam logic [31:0] mstatus_reset = 32'h0000_1800;
  localparam logic [31:0] mvendorid_val = 32'h7973_7978;
  localparam logic [31:0] marchid_val   = 32'h017d_c685;
  localparam logic [31:0] ecall_cause   = 32'd11;

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

  typedef enum logic [2:0] {
    add,
    sub,
    pass_imm,
    csr_rw,
    csr_rs,
    ecall,
    mret,
    nop
  } alu_op_e;

  // decoded instruction.
  typedef struct packed {
    logic [31:0] pc;
    alu_op_e     alu_op;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [31:0] imm;
    logic [11:0] csr_addr;
    logic        use_imm;
  } du_bus_t;

  // operands read from the register file.
  typedef struct packed {
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] csr_data;
  } gu_bus_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [3:0]  rd;
    logic        gpr_wen;
    logic [31:0] gpr_wdata;
    logic        csr_wen;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    alu_op_e     alu_op;
    logic [31:0] npc;
  } eu_bus_t;

  // state update back into gpr.
  typedef struct packed {
    logic [3:0]  rd;
    logic        gpr_wen;
    logic [31:0] gpr_wdata;
    logic        csr_wen;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] pc;
    logic        is_ecall;
    logic        is_mret;
  } wu_bus_t;

  typedef struct packed {
    logic [3:0]  rd;
    logic        gpr_wen;
    logic [31:0] wdata;
    logic [31:0] npc;
  } commit_t;

endpackage

// File: verilog/idu.sv
`timescale 1ns/1ps

module idu (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  input  isa_pkg::inst_u    inst,
  input  logic [31:0]       pc,
  output logic              inst_ready,
  input  logic              commit_done,
  output logic              idu_valid,
  output core_pkg::du_bus_t du_bus
);
  import isa_pkg::*;
  import core_pkg::*;

  logic    busy;
  logic    accept;
  du_bus_t dec;

  assign inst_ready = ~busy;
  assign accept     = inst_valid & ~busy;

  always_comb begin
    dec          = '0;
    dec.pc       = pc;
    dec.alu_op   = nop;
    dec.rd       = inst.i_fmt.rd[3:0];
    dec.rs1      = inst.i_fmt.rs1[3:0];
    dec.imm      = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    dec.csr_addr = inst.i_fmt.imm12;
    case (inst.i_fmt.opcode)
      op_imm: begin
        if (inst.i_fmt.funct3 == f3_add) begin
          dec.alu_op  = add;
          dec.use_imm = 1'b1;
        end
      end
      op_reg: begin
        dec.rs2 = inst.r_fmt.rs2[3:0];
        if (inst.r_fmt.funct3 == f3_add && inst.r_fmt.funct7 == f7_base) begin
          dec.alu_op = add;
        end else if (inst.r_fmt.funct3 == f3_add && inst.r_fmt.funct7 == f7_sub) begin
          dec.alu_op = sub;
        end
      end
      op_lui: begin
        dec.alu_op = pass_imm;
        dec.imm    = {inst.i_fmt.imm12, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000};
      end
      op_system: begin
        case (inst.i_fmt.funct3)
          f3_csrrw: dec.alu_op = csr_rw;
          f3_csrrs: dec.alu_op = csr_rs;
          f3_priv: begin
            // only the bare encodings count.
            if (inst.i_fmt.rd == 5'd0 && inst.i_fmt.rs1 == 5'd0) begin
              if (inst.i_fmt.imm12 == imm_ecall) begin
                dec.alu_op = ecall;
              end else if (inst.i_fmt.imm12 == imm_mret) begin
                dec.alu_op = mret;
              end
            end
          end
          default: dec.alu_op = nop;
        endcase
      end
      default: dec.alu_op = nop;
    endcase
  end

  // busy from accept until the commit edge.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy      <= 1'b0;
      idu_valid <= 1'b0;
    end else begin
      idu_valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (commit_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      du_bus <= dec;
    end
  end

endmodule

// File: verilog/gpr.sv
`timescale 1ns/1ps

module gpr (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::du_bus_t du_bus,
  output core_pkg::gu_bus_t gu_bus,
  input  logic              wbu_valid,
  input  core_pkg::wu_bus_t wu_bus
);
  import isa_pkg::*;
  import core_pkg::*;

  logic [31:0] regs [16];
  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] csr_rdata;
  logic [31:0] mret_status;

  always_comb begin
    case (du_bus.csr_addr)
      csr_mstatus:   csr_rdata = mstatus;
      csr_mtvec:     csr_rdata = mtvec;
      csr_mepc:      csr_rdata = mepc;
      csr_mcause:    csr_rdata = mcause;
      csr_mvendorid: csr_rdata = mvendorid_val;
      csr_marchid:   csr_rdata = marchid_val;
      default:       csr_rdata = '0;
    endcase
  end

  // trap entry and return read their target pc here.
  always_comb begin
    gu_bus.src1 = regs[du_bus.rs1];
    gu_bus.src2 = regs[du_bus.rs2];
    if (du_bus.alu_op == ecall) begin
      gu_bus.csr_data = mtvec;
    end else if (du_bus.alu_op == mret) begin
      gu_bus.csr_data = mepc;
    end else begin
      gu_bus.csr_data = csr_rdata;
    end
  end

  // mie <= mpie, mpie set, mpp back to user.
  always_comb begin
    mret_status                      = mstatus;
    mret_status[mstatus_mie]         = mstatus[mstatus_mpie];
    mret_status[mstatus_mpie]        = 1'b1;
    mret_status[mstatus_mpp_lo +: 2] = 2'b00;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wbu_valid && wu_bus.gpr_wen && wu_bus.rd != 4'd0) begin
      regs[wu_bus.rd] <= wu_bus.gpr_wdata;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (wbu_valid) begin
      if (wu_bus.is_ecall) begin
        mepc    <= wu_bus.pc;
        mcause  <= ecall_cause;
        mstatus <= mstatus_reset;
      end else if (wu_bus.is_mret) begin
        mstatus <= mret_status;
      end else if (wu_bus.csr_wen) begin
        // read-only and unknown addresses drop the write.
        case (wu_bus.csr_addr)
          csr_mstatus: mstatus <= wu_bus.csr_wdata;
          csr_mtvec:   mtvec   <= wu_bus.csr_wdata;
          csr_mepc:    mepc    <= wu_bus.csr_wdata;
          csr_mcause:  mcause  <= wu_bus.csr_wdata;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: verilog/exu.sv
`timescale 1ns/1ps

module exu (
  input  logic              clk,
  input  logic              rst,
  input  logic              idu_valid,
  input  core_pkg::du_bus_t du_bus,
  input  core_pkg::gu_bus_t gu_bus,
  output logic              exu_valid,
  output core_pkg::eu_bus_t eu_bus
);
  import core_pkg::*;

  logic [31:0] opnd2;
  eu_bus_t     res;

  assign opnd2 = du_bus.use_imm ? du_bus.imm : gu_bus.src2;

  always_comb begin
    res          = '0;
    res.pc       = du_bus.pc;
    res.rd       = du_bus.rd;
    res.alu_op   = du_bus.alu_op;
    res.csr_addr = du_bus.csr_addr;
    res.npc      = du_bus.pc + 32'd4;
    case (du_bus.alu_op)
      add: begin
        res.gpr_wen   = 1'b1;
        res.gpr_wdata = gu_bus.src1 + opnd2;
      end
      sub: begin
        res.gpr_wen   = 1'b1;
        res.gpr_wdata = gu_bus.src1 - opnd2;
      end
      pass_imm: begin
        res.gpr_wen   = 1'b1;
        res.gpr_wdata = du_bus.imm;
      end
      // rd gets the old csr value.
      csr_rw, csr_rs: begin
        res.gpr_wen   = 1'b1;
        res.gpr_wdata = gu_bus.csr_data;
        res.csr_wen   = 1'b1;
        res.csr_wdata = (du_bus.alu_op == csr_rs) ? (gu_bus.csr_data | gu_bus.src1)
                                                  : gu_bus.src1;
      end
      ecall, mret: res.npc = gu_bus.csr_data;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      exu_valid <= 1'b0;
    end else begin
      exu_valid <= idu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (idu_valid) begin
      eu_bus <= res;
    end
  end

endmodule

// File: verilog/wbu.sv
`timescale 1ns/1ps

module wbu (
  input  logic              clk,
  input  logic              rst,
  input  logic              exu_valid,
  input  core_pkg::eu_bus_t eu_bus,
  output logic              wbu_valid,
  output core_pkg::wu_bus_t wu_bus,
  output core_pkg::commit_t commit
);
  import core_pkg::*;

  eu_bus_t eu_q;
  logic    gpr_wen;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wbu_valid <= 1'b0;
    end else begin
      wbu_valid <= exu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exu_valid) begin
      eu_q <= eu_bus;
    end
  end

  // x0 is never reported as written.
  assign gpr_wen = eu_q.gpr_wen && (eu_q.rd != 4'd0);

  always_comb begin
    wu_bus.rd        = eu_q.rd;
    wu_bus.gpr_wen   = gpr_wen;
    wu_bus.gpr_wdata = eu_q.gpr_wdata;
    wu_bus.csr_wen   = eu_q.csr_wen;
    wu_bus.csr_addr  = eu_q.csr_addr;
    wu_bus.csr_wdata = eu_q.csr_wdata;
    wu_bus.pc        = eu_q.pc;
    wu_bus.is_ecall  = (eu_q.alu_op == ecall);
    wu_bus.is_mret   = (eu_q.alu_op == mret);
  end

  always_comb begin
    commit.rd      = eu_q.rd;
    commit.gpr_wen = gpr_wen;
    commit.wdata   = gpr_wen ? eu_q.gpr_wdata : '0;
    commit.npc     = eu_q.npc;
  end

endmodule

// File: verilog/rv32e_core.sv
`timescale 1ns/1ps

module rv32e_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid,
  input  logic [31:0]       inst,
  input  logic [31:0]       pc,
  output logic              inst_ready,
  output logic              commit_valid,
  output core_pkg::commit_t commit
);
  import core_pkg::*;

  logic    idu_valid;
  logic    exu_valid;
  logic    wbu_valid;
  du_bus_t du_bus;
  gu_bus_t gu_bus;
  eu_bus_t eu_bus;
  wu_bus_t wu_bus;

  idu idu0 (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .inst_ready (inst_ready),
    .commit_done(wbu_valid),
    .idu_valid  (idu_valid),
    .du_bus     (du_bus)
  );

  gpr gpr0 (
    .clk      (clk),
    .rst      (rst),
    .du_bus   (du_bus),
    .gu_bus   (gu_bus),
    .wbu_valid(wbu_valid),
    .wu_bus   (wu_bus)
  );

  exu exu0 (
    .clk      (clk),
    .rst      (rst),
    .idu_valid(idu_valid),
    .du_bus   (du_bus),
    .gu_bus   (gu_bus),
    .exu_valid(exu_valid),
    .eu_bus   (eu_bus)
  );

  wbu wbu0 (
    .clk      (clk),
    .rst      (rst),
    .exu_valid(exu_valid),
    .eu_bus   (eu_bus),
    .wbu_valid(wbu_valid),
    .wu_bus   (wu_bus),
    .commit   (commit)
  );

  assign commit_valid = wbu_valid;

endmodule

// File: sim/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
  input logic              clk,
  input logic              rst,
  input logic              inst_valid,
  input logic              inst_ready,
  input logic              commit_valid,
  input core_pkg::commit_t commit
);

  // accept to commit is fixed at three cycles.
  assert property (@(posedge clk) disable iff (rst)
    (inst_valid && inst_ready) |-> ##3 commit_valid)
    else $error("commit did not follow accept by 3 cycles");

  assert property (@(posedge clk) disable iff (rst)
    commit_valid |=> !commit_valid)
    else $error("commit_valid held for more than one cycle");

  // no second accept while in flight.
  assert property (@(posedge clk) disable iff (rst)
    (inst_valid && inst_ready) |=> !inst_ready ##1 !inst_ready ##1 !inst_ready)
    else $error("inst_ready high while an instruction is in flight");

  assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> !(commit.gpr_wen && commit.rd == 4'd0))
    else $error("commit reports a write to x0");

endmodule

bind rv32e_core core_assertions chk0 (
  .clk         (clk),
  .rst         (rst),
  .inst_valid  (inst_valid),
  .inst_ready  (inst_ready),
  .commit_valid(commit_valid),
  .commit      (commit)
);

// File: sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;
  import isa_pkg::*;
  import core_pkg::*;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] pc;
    logic [3:0]  rd;
    logic        wen;
    logic [31:0] wdata;
    logic [31:0] npc;
  } row_t;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        inst_ready;
  logic        commit_valid;
  commit_t     commit;

  row_t        rows[$];
  string       names[$];
  int          seed;
  int          errors;
  int          checks;
  int          cycles;
  int          limit;
  int          n;
  logic [31:0] rnd;
  logic [31:0] sa;
  logic [31:0] sb;
  logic [31:0] sc;
  logic [31:0] trap_pc;
  logic [31:0] ms_v;
  logic [31:0] ms_ret;

  rv32e_core dut0 (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .inst_ready  (inst_ready),
    .commit_valid(commit_valid),
    .commit      (commit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, op_reg};
  endfunction

  function automatic logic [31:0] next_pc();
    return 32'h0000_0100 + rows.size() * 4;
  endfunction

  task automatic add_jump_row(input string name, input logic [31:0] word, input logic [3:0] rd,
                              input logic wen, input logic [31:0] wdata, input logic [31:0] npc);
    row_t r;
    r.word  = word;
    r.pc    = next_pc();
    r.rd    = rd;
    r.wen   = wen;
    r.wdata = wdata;
    r.npc   = npc;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_row(input string name, input logic [31:0] word, input logic [3:0] rd,
                         input logic wen, input logic [31:0] wdata);
    add_jump_row(name, word, rd, wen, wdata, next_pc() + 32'd4);
  endtask

  task automatic check_value(input string name, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h, actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  // csr reads after reset.
  task automatic build_table();
    add_row("rd_mstatus", enc_i(csr_mstatus, 5'd0, f3_csrrs, 5'd1, op_system), 4'd1, 1'b1,
            32'h0000_1800);
    add_row("rd_mvendorid", enc_i(csr_mvendorid, 5'd0, f3_csrrs, 5'd2, op_system), 4'd2, 1'b1,
            mvendorid_val);
    add_row("rd_marchid", enc_i(csr_marchid, 5'd0, f3_csrrs, 5'd3, op_system), 4'd3, 1'b1,
            marchid_val);
    add_row("rd_mtvec", enc_i(csr_mtvec, 5'd0, f3_csrrs, 5'd4, op_system), 4'd4, 1'b1, 32'd0);
    add_row("addi_a", enc_i(sa[11:0], 5'd0, 3'b000, 5'd5, op_imm), 4'd5, 1'b1, sa);
    add_row("addi_b", enc_i(sb[11:0], 5'd0, 3'b000, 5'd6, op_imm), 4'd6, 1'b1, sb);
    add_row("add", enc_r(7'b0000000, 5'd6, 5'd5, 5'd7), 4'd7, 1'b1, sa + sb);
    add_row("sub", enc_r(7'b0100000, 5'd6, 5'd5, 5'd8), 4'd8, 1'b1, sa - sb);
    add_row("addi_chain", enc_i(sc[11:0], 5'd7, 3'b000, 5'd9, op_imm), 4'd9, 1'b1, sa + sb + sc);
    add_row("lui", {20'habcde, 5'd10, op_lui}, 4'd10, 1'b1, 32'habcd_e000);
    add_row("addi_x0", enc_i(sa[11:0], 5'd0, 3'b000, 5'd0, op_imm), 4'd0, 1'b0, 32'd0);
    add_row("add_x0_rd", enc_r(7'b0000000, 5'd0, 5'd0, 5'd11), 4'd11, 1'b1, 32'd0);
    add_row("csrrw_mtvec", enc_i(csr_mtvec, 5'd10, f3_csrrw, 5'd13, op_system), 4'd13, 1'b1, 32'd0);
    add_row("csrrw_mepc", enc_i(csr_mepc, 5'd8, f3_csrrw, 5'd14, op_system), 4'd14, 1'b1, 32'd0);
    add_row("csrrs_mtvec", enc_i(csr_mtvec, 5'd9, f3_csrrs, 5'd15, op_system), 4'd15, 1'b1,
            32'habcd_e000);
    add_row("rd_mtvec_or", enc_i(csr_mtvec, 5'd0, f3_csrrs, 5'd15, op_system), 4'd15, 1'b1,
            32'habcd_e000 | (sa + sb + sc));
    add_row("rd_mepc", enc_i(csr_mepc, 5'd0, f3_csrrs, 5'd1, op_system), 4'd1, 1'b1, sa - sb);
    // move mstatus away from its reset value.
    add_row("csrrs_mstatus", enc_i(csr_mstatus, 5'd10, f3_csrrs, 5'd1, op_system), 4'd1, 1'b1,
            32'h0000_1800);
    // trap entry jumps to mtvec.
    trap_pc = next_pc();
    add_jump_row("ecall", enc_i(imm_ecall, 5'd0, 3'b000, 5'd0, op_system), 4'd0, 1'b0, 32'd0,
                 32'habcd_e000 | (sa + sb + sc));
    add_row("rd_mepc_ecall", enc_i(csr_mepc, 5'd0, f3_csrrs, 5'd2, op_system), 4'd2, 1'b1, trap_pc);
    add_row("rd_mcause", enc_i(csr_mcause, 5'd0, f3_csrrs, 5'd3, op_system), 4'd3, 1'b1, 32'd11);
    add_row("rd_mstatus_ecall", enc_i(csr_mstatus, 5'd0, f3_csrrs, 5'd4, op_system), 4'd4, 1'b1,
            32'h0000_1800);
    ms_v = 32'h0000_2000 + sext12(12'h808);
    // mie takes mpie, mpie set, mpp cleared.
    ms_ret = (ms_v & ~32'h0000_1888) | 32'h0000_0080 | {28'd0, ms_v[7], 3'b000};
    add_row("lui_ms", {20'h00002, 5'd12, op_lui}, 4'd12, 1'b1, 32'h0000_2000);
    add_row("addi_ms", enc_i(12'h808, 5'd12, 3'b000, 5'd12, op_imm), 4'd12, 1'b1, ms_v);
    add_row("csrrw_mstatus", enc_i(csr_mstatus, 5'd12, f3_csrrw, 5'd13, op_system), 4'd13, 1'b1,
            32'h0000_1800);
    add_jump_row("mret", enc_i(imm_mret, 5'd0, 3'b000, 5'd0, op_system), 4'd0, 1'b0, 32'd0,
                 trap_pc);
    add_row("rd_mstatus_mret", enc_i(csr_mstatus, 5'd0, f3_csrrs, 5'd14, op_system), 4'd14, 1'b1,
            ms_ret);
    add_row("nop_zero", 32'h0000_0000, 4'd0, 1'b0, 32'd0);
    add_row("nop_addi", enc_i(12'h000, 5'd0, 3'b000, 5'd0, op_imm), 4'd0, 1'b0, 32'd0);
  endtask

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    errors     = 0;
    checks     = 0;
    limit      = 0;
    seed       = 49668;
    rnd = $random(seed);
    sa  = sext12(rnd[11:0]);
    rnd = $random(seed);
    sb  = sext12(rnd[11:0]);
    rnd = $random(seed);
    sc  = sext12(rnd[11:0]);
    build_table();
    limit = rows.size() * 8 + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      n = 0;
      while (!inst_ready && n < 6) begin
        @(negedge clk);
        n++;
      end
      if (!inst_ready) begin
        $display("core not ready for %s", names[i]);
        errors++;
      end
      inst_valid = 1'b1;
      inst       = rows[i].word;
      pc         = rows[i].pc;
      @(negedge clk);
      inst_valid = 1'b0;
      n = 1;
      while (!commit_valid && n < 6) begin
        @(negedge clk);
        n++;
      end
      if (!commit_valid) begin
        $display("no commit for %s within 6 cycles of the accept", names[i]);
        errors++;
      end else begin
        check_value(names[i], "latency", 32'd3, n);
        check_value(names[i], "rd", {28'd0, rows[i].rd}, {28'd0, commit.rd});
        check_value(names[i], "gpr_wen", {31'd0, rows[i].wen}, {31'd0, commit.gpr_wen});
        check_value(names[i], "wdata", rows[i].wdata, commit.wdata);
        check_value(names[i], "npc", rows[i].npc, commit.npc);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: rv32e_core.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/idu.sv
verilog/gpr.sv
verilog/exu.sv
verilog/wbu.sv
verilog/rv32e_core.sv
sim/core_assertions.sv
sim/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the rv32e_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f rv32e_core.f \
  && ./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "all tests passed" \
  && echo "simulation: PASS" \
  || { echo "simulation: FAIL"; exit 1; }
